/* design/dct_defines.svh */
// Size macros for the 16-point row DCT, included by the packages and the RTL modules
`ifndef DCT_DEFINES_SVH
`define DCT_DEFINES_SVH

// Points in one row
`define DCT_N 16

// Unsigned input pixel width
`define DCT_PIXEL_W 8

// Signed output coefficient width
`define DCT_COEF_W 11

// Low bits dropped after exact accumulation
// i.e. the result is floor(sum / 64)
`define DCT_FRAC_BITS 6

// Exact product sum width
// Worst case is 16 * 255 * 45, well inside 19 bits plus sign
`define DCT_ACC_W 20

// Cosine table constant width
`define DCT_CONST_W 7

`endif

/* design/dct_types_pkg.sv */
// Vector and row types shared by the DCT RTL and the testbench, pulled in by wildcard import
`include "dct_defines.svh"

package dct_types_pkg;

    // Unsigned input pixel
    typedef logic [`DCT_PIXEL_W-1:0] pixel_t;

    // Butterfly sum or difference
    // Sum needs one extra bit, difference needs the sign
    typedef logic signed [`DCT_PIXEL_W+1:0] bfly_t;

    // Exact weighted sum before truncation
    typedef logic signed [`DCT_ACC_W-1:0] acc_t;

    // Output coefficient
    typedef logic signed [`DCT_COEF_W-1:0] coef_t;

    // One input row, px[0] is the first pixel
    typedef struct packed {
        pixel_t [`DCT_N-1:0] px;
    } pixel_row_t;

    // First butterfly result
    // sum[n] = px[n] + px[15-n], diff[n] = px[n] - px[15-n]
    typedef struct packed {
        bfly_t [`DCT_N/2-1:0] sum;
        bfly_t [`DCT_N/2-1:0] diff;
    } bfly_row_t;

    // Eight coefficients from the even or the odd part
    typedef struct packed {
        coef_t [`DCT_N/2-1:0] c;
    } half_coef_t;

    // Full output row, x[k] is X[k]
    typedef struct packed {
        coef_t [`DCT_N-1:0] x;
    } coef_row_t;

endpackage

/* design/dct_coef_pkg.sv */
// Cosine table, weight rule and truncation for the row DCT, used by the datapath and the model
`include "dct_defines.svh"

package dct_coef_pkg;

    import dct_types_pkg::*;

    // C[m] ~ 45.25 * cos(m*pi/32), except C[0] which carries the DC scale
    localparam logic [`DCT_CONST_W-1:0] COS_TABLE [`DCT_N] = '{
        7'd32, 7'd45, 7'd44, 7'd43, 7'd42, 7'd40, 7'd38, 7'd35,
        7'd32, 7'd29, 7'd25, 7'd21, 7'd17, 7'd13, 7'd9,  7'd4
    };

    // Full period of the phase index k*(2n+1)
    localparam int PHASE_PERIOD = 4 * `DCT_N;

    // Signed weight of pixel n in output k
    function automatic int dct_weight(input int k, input int n);
        int p;
        int w;
        p = (k * (2 * n + 1)) % PHASE_PERIOD;
        if (k == 0) begin
            w = int'(COS_TABLE[0]);
        end else if (p == `DCT_N || p == 3 * `DCT_N) begin
            // Cosine zero crossing, only reachable for k a multiple of 16
            w = 0;
        end else if (p < `DCT_N) begin
            // First quadrant
            w = int'(COS_TABLE[p]);
        end else if (p < 2 * `DCT_N) begin
            // Second quadrant mirrors with negative sign
            w = -int'(COS_TABLE[2 * `DCT_N - p]);
        end else if (p < 3 * `DCT_N) begin
            w = -int'(COS_TABLE[p - 2 * `DCT_N]);
        end else begin
            // Fourth quadrant back to positive
            w = int'(COS_TABLE[PHASE_PERIOD - p]);
        end
        return w;
    endfunction

    // Floor divide by 2^FRAC and keep the low coefficient bits
    // Arithmetic shift of two's complement already floors
    function automatic coef_t drop_frac(input acc_t acc);
        return acc[`DCT_FRAC_BITS +: `DCT_COEF_W];
    endfunction

endpackage

/* design/dct_pipe_ctrl.sv */
// Keeps the valid bits and load enables of the two DCT register stages for the top to instantiate
`timescale 1ns/1ps

module dct_pipe_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  logic out_ready,
    output logic out_valid,
    output logic s1_en,
    output logic s2_en
);

    // Stage 1 holds a row
    logic s1_valid;
    // Stage 2 may take a new row this cycle
    logic s2_advance;

    // Stage 2 empty or its row leaving now
    assign s2_advance = !out_valid || out_ready;

    // Stage 1 free once its row moves on
    assign in_ready = !s1_valid || s2_advance;

    assign s1_en = in_valid && in_ready;
    assign s2_en = s1_valid && s2_advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                s1_valid <= in_valid;
            end
            // Bubble moves forward when stage 1 is empty
            if (s2_advance) begin
                out_valid <= s1_valid;
            end
        end
    end

    // A stalled output row is never withdrawn
    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid
    ) else $error("out_valid dropped before acceptance");

    // A stage 1 row waits until stage 2 takes it
    a_s1_hold: assert property (
        @(posedge clk) disable iff (reset)
        s1_valid && !s2_en |=> s1_valid
    ) else $error("stage 1 row dropped before stage 2 took it");

endmodule

/* design/dct_input_butterfly.sv */
// Registered first DCT butterfly, sums and differences of pixel n and pixel 15-n
`timescale 1ns/1ps
`include "dct_defines.svh"

module dct_input_butterfly
    import dct_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       s1_en,
    input  pixel_row_t in_row,
    output bfly_row_t  s1_row
);

    localparam int HALF = `DCT_N / 2;

    // Largest pair sum of two full-scale pixels
    localparam bfly_t SUM_MAX = bfly_t'(2 * (2 ** `DCT_PIXEL_W - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_row <= '0;
        end else if (s1_en) begin
            for (int n = 0; n < HALF; n++) begin
                // Zero extend so the sum cannot wrap
                s1_row.sum[n]  <= {2'b00, in_row.px[n]} + {2'b00, in_row.px[`DCT_N-1-n]};
                // Wraps into the signed range -255..255
                s1_row.diff[n] <= {2'b00, in_row.px[n]} - {2'b00, in_row.px[`DCT_N-1-n]};
            end
        end
    end

    // Even part relies on non-negative sums that fit the butterfly width
    for (genvar n = 0; n < HALF; n++) begin : g_sum_check
        a_sum_range: assert property (
            @(posedge clk) disable iff (reset)
            s1_en |=> (s1_row.sum[n] >= 0) && (s1_row.sum[n] <= SUM_MAX)
        ) else $error("pair sum %0d out of range", n);
    end

endmodule

/* design/dct_even_part.sv */
// Registered 8-point even DCT half, turns the pair sums into X[0], X[2] ... X[14]
`timescale 1ns/1ps
`include "dct_defines.svh"

module dct_even_part
    import dct_types_pkg::*;
    import dct_coef_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s2_en,
    input  bfly_t [`DCT_N/2-1:0]        sums,
    output half_coef_t                  even_coefs
);

    localparam int HALF  = `DCT_N / 2;
    localparam int QUART = `DCT_N / 4;

    // Second butterfly level
    acc_t lvl2_sum [QUART];
    acc_t lvl2_dif [QUART];

    // Constant products of the level 2 differences
    // C2 = 44, C6 = 38, C10 = 25, C14 = 9
    acc_t p44 [QUART];
    acc_t p38 [QUART];
    acc_t p25 [QUART];
    acc_t p9  [QUART];

    // Third butterfly level on the level 2 sums
    acc_t e0, e1, f0, f1;

    // Exact even coefficients
    acc_t x0, x2, x4, x6, x8, x10, x12, x14;

    for (genvar i = 0; i < QUART; i++) begin : g_level2
        assign lvl2_sum[i] = acc_t'(sums[i]) + acc_t'(sums[HALF-1-i]);
        assign lvl2_dif[i] = acc_t'(sums[i]) - acc_t'(sums[HALF-1-i]);

        // Each difference meets every odd-of-even constant exactly once
        assign p44[i] = (lvl2_dif[i] <<< 5) + (lvl2_dif[i] <<< 3) + (lvl2_dif[i] <<< 2);
        assign p38[i] = (lvl2_dif[i] <<< 5) + (lvl2_dif[i] <<< 2) + (lvl2_dif[i] <<< 1);
        assign p25[i] = (lvl2_dif[i] <<< 4) + (lvl2_dif[i] <<< 3) + lvl2_dif[i];
        assign p9[i]  = (lvl2_dif[i] <<< 3) + lvl2_dif[i];
    end

    assign e0 = lvl2_sum[0] + lvl2_sum[3];
    assign e1 = lvl2_sum[1] + lvl2_sum[2];
    assign f0 = lvl2_sum[0] - lvl2_sum[3];
    assign f1 = lvl2_sum[1] - lvl2_sum[2];

    // DC and X[8], both scaled by 32
    assign x0 = (e0 + e1) <<< 5;
    assign x8 = (e0 - e1) <<< 5;

    // C4 = 42, C12 = 17
    assign x4  = (f0 <<< 5) + (f0 <<< 3) + (f0 <<< 1) + (f1 <<< 4) + f1;
    assign x12 = (f0 <<< 4) + f0 - ((f1 <<< 5) + (f1 <<< 3) + (f1 <<< 1));

    // Rows of the 4-point odd kernel
    assign x2  = p44[0] + p38[1] + p25[2] + p9[3];
    assign x6  = p38[0] - p9[1]  - p44[2] - p25[3];
    assign x10 = p25[0] - p44[1] + p9[2]  + p38[3];
    assign x14 = p9[0]  - p25[1] + p38[2] - p44[3];

    always_ff @(posedge clk) begin
        if (reset) begin
            even_coefs <= '0;
        end else if (s2_en) begin
            // c[j] holds X[2j]
            even_coefs.c[0] <= drop_frac(x0);
            even_coefs.c[1] <= drop_frac(x2);
            even_coefs.c[2] <= drop_frac(x4);
            even_coefs.c[3] <= drop_frac(x6);
            even_coefs.c[4] <= drop_frac(x8);
            even_coefs.c[5] <= drop_frac(x10);
            even_coefs.c[6] <= drop_frac(x12);
            even_coefs.c[7] <= drop_frac(x14);
        end
    end

endmodule

/* design/dct_odd_part.sv */
// Registered odd DCT half, turns the pair differences into X[1], X[3] ... X[15]
`timescale 1ns/1ps
`include "dct_defines.svh"

module dct_odd_part
    import dct_types_pkg::*;
    import dct_coef_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 s2_en,
    input  bfly_t [`DCT_N/2-1:0] diffs,
    output half_coef_t           odd_coefs
);

    localparam int HALF  = `DCT_N / 2;
    localparam int QUART = `DCT_N / 4;

    // Truncated odd coefficients ahead of the register
    coef_t next_c [HALF];

    // Shift-and-add product with a signed table weight
    // Weight is an elaboration constant, so only the set bits become adders
    function automatic acc_t mul_const(input bfly_t x, input int w);
        acc_t x_ext;
        acc_t prod;
        int   mag;
        x_ext = x;
        mag   = (w < 0) ? -w : w;
        prod  = '0;
        for (int b = 0; b < `DCT_CONST_W; b++) begin
            if (mag[b]) begin
                prod = prod + (x_ext <<< b);
            end
        end
        return (w < 0) ? -prod : prod;
    endfunction

    for (genvar j = 0; j < HALF; j++) begin : g_coef
        // Products paired as diff[i] with its mirror diff[7-i]
        acc_t pair_sum [QUART];
        acc_t total;

        for (genvar i = 0; i < QUART; i++) begin : g_pair
            localparam int W_LO = dct_weight(2 * j + 1, i);
            localparam int W_HI = dct_weight(2 * j + 1, HALF - 1 - i);

            assign pair_sum[i] = mul_const(diffs[i], W_LO)
                               + mul_const(diffs[HALF-1-i], W_HI);
        end

        // Exact sum of all eight products
        assign total = pair_sum[0] + pair_sum[1] + pair_sum[2] + pair_sum[3];
        assign next_c[j] = drop_frac(total);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            odd_coefs <= '0;
        end else if (s2_en) begin
            // c[j] holds X[2j+1]
            for (int j = 0; j < HALF; j++) begin
                odd_coefs.c[j] <= next_c[j];
            end
        end
    end

endmodule

/* design/dct_row_top.sv */
// Pipelined 16-point row DCT top, instantiate with a valid/ready pixel row in and coefficient row out
`timescale 1ns/1ps
`include "dct_defines.svh"

module dct_row_top
    import dct_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Pixel row stream
    input  logic       in_valid,
    output logic       in_ready,
    input  pixel_row_t in_row,

    // Coefficient row stream
    output logic       out_valid,
    input  logic       out_ready,
    output coef_row_t  out_row
);

    // Load enables from the control
    logic       s1_en;
    logic       s2_en;

    // Stage 1 register contents
    bfly_row_t  s1_row;

    // Stage 2 halves
    half_coef_t even_coefs;
    half_coef_t odd_coefs;

    // Valid/ready bookkeeping for both stages
    dct_pipe_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .s1_en     (s1_en),
        .s2_en     (s2_en)
    );

    // Stage 1, mirrored pair sums and differences
    dct_input_butterfly u_bfly (
        .clk    (clk),
        .reset  (reset),
        .s1_en  (s1_en),
        .in_row (in_row),
        .s1_row (s1_row)
    );

    // Stage 2 even half works on sums only
    dct_even_part u_even (
        .clk        (clk),
        .reset      (reset),
        .s2_en      (s2_en),
        .sums       (s1_row.sum),
        .even_coefs (even_coefs)
    );

    // Stage 2 odd half works on differences only
    dct_odd_part u_odd (
        .clk       (clk),
        .reset     (reset),
        .s2_en     (s2_en),
        .diffs     (s1_row.diff),
        .odd_coefs (odd_coefs)
    );

    // Interleave the halves back into X[0..15]
    always_comb begin
        for (int k = 0; k < `DCT_N / 2; k++) begin
            out_row.x[2 * k]     = even_coefs.c[k];
            out_row.x[2 * k + 1] = odd_coefs.c[k];
        end
    end

endmodule

/* verification/tb_dct_row_tasks.svh */
// Reference model, compare tasks, row driver and directed tests, included inside the testbench top
`ifndef TB_DCT_ROW_TASKS_SVH
`define TB_DCT_ROW_TASKS_SVH

// Cosine table of the transform, C[0] is the DC weight
localparam int COS_REF [`DCT_N] = '{32, 45, 44, 43, 42, 40, 38, 35,
                                    32, 29, 25, 21, 17, 13, 9, 4};

// Signed weight of pixel n in X[k], folded by cosine symmetry
function automatic int model_weight(input int k, input int n);
    int phase;
    int sign;
    if (k == 0) begin
        return COS_REF[0];
    end
    phase = (k * (2 * n + 1)) % (4 * `DCT_N);
    sign  = 1;
    // cos(2pi - a) equals cos(a)
    if (phase > 2 * `DCT_N) begin
        phase = 4 * `DCT_N - phase;
    end
    // cos(pi - a) flips the sign
    if (phase > `DCT_N) begin
        phase = 2 * `DCT_N - phase;
        sign  = -1;
    end
    if (phase == `DCT_N) begin
        return 0;
    end
    return sign * COS_REF[phase];
endfunction

// Floor divide by 64, keep the low 11 bits
function automatic coef_t floor_coef(input int acc);
    return coef_t'(acc >>> `DCT_FRAC_BITS);
endfunction

function automatic coef_row_t model_row(input pixel_row_t row);
    coef_row_t res;
    int        acc;
    for (int k = 0; k < `DCT_N; k++) begin
        acc = 0;
        for (int n = 0; n < `DCT_N; n++) begin
            acc += model_weight(k, n) * int'(row.px[n]);
        end
        res.x[k] = floor_coef(acc);
    end
    return res;
endfunction

function automatic pixel_row_t random_row();
    pixel_row_t row;
    for (int n = 0; n < `DCT_N; n++) begin
        row.px[n] = pixel_t'($urandom);
    end
    return row;
endfunction

task automatic check_coef_row(input string name, input coef_row_t got, input coef_row_t exp);
    for (int k = 0; k < `DCT_N; k++) begin
        if (got.x[k] !== exp.x[k]) begin
            value_errors++;
            $display("FAILED %s.x[%0d]: got %h expected %h", name, k, got.x[k], exp.x[k]);
        end
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

// Queue the expected row, then hold the input until the transfer edge
task automatic send_row(input pixel_row_t row, input coef_row_t exp);
    expected_rows.push_back(exp);
    in_row   = row;
    in_valid = 1'b1;
    do begin
        @(posedge clk);
    end while (!in_ready);
    #1;
    in_valid = 1'b0;
endtask

// Every queued row checked, plus a short idle gap
task automatic wait_drained();
    while (expected_rows.size() != 0) begin
        @(posedge clk);
        #1;
    end
    repeat (2) @(posedge clk);
    #1;
endtask

task automatic test_reset_state();
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
endtask

// Zero row, then constant rows where only X[0] = 8v survives
task automatic test_flat_rows();
    pixel_row_t row;
    coef_row_t  exp;
    int         levels [4] = '{1, 100, 200, 255};
    send_row('0, '0);
    for (int i = 0; i < 4; i++) begin
        for (int n = 0; n < `DCT_N; n++) begin
            row.px[n] = pixel_t'(levels[i]);
        end
        exp      = '0;
        exp.x[0] = coef_t'(8 * levels[i]);
        send_row(row, exp);
    end
    wait_drained();
endtask

// Full-scale impulse at each column n reads back column n of the weights
task automatic test_impulse_rows();
    pixel_row_t row;
    coef_row_t  exp;
    for (int n = 0; n < `DCT_N; n++) begin
        row       = '0;
        row.px[n] = 8'd255;
        for (int k = 0; k < `DCT_N; k++) begin
            exp.x[k] = floor_coef(255 * model_weight(k, n));
        end
        send_row(row, exp);
    end
    wait_drained();
endtask

task automatic test_random_stream();
    pixel_row_t row;
    latency_check = 1'b1;
    for (int i = 0; i < 200; i++) begin
        row = random_row();
        send_row(row, model_row(row));
    end
    wait_drained();
endtask

// Random stalls on the output, random gaps on the input
task automatic test_backpressure();
    pixel_row_t row;
    latency_check = 1'b0;
    toggle_ready  = 1'b1;
    for (int i = 0; i < 100; i++) begin
        if ($urandom % 4 == 0) begin
            @(posedge clk);
            #1;
        end
        row = random_row();
        send_row(row, model_row(row));
    end
    wait_drained();
    toggle_ready = 1'b0;
    @(posedge clk);
    #1;
endtask

`endif

/* verification/tb_dct_row.sv */
// Testbench top for the row DCT, runs the directed tests on u_dut and prints the verdict
`timescale 1ns/1ps
`include "dct_defines.svh"

module tb_dct_row
    import dct_types_pkg::*;
();

    // Rows over all tests, sets the watchdog limit
    localparam int TOTAL_ROWS  = 1 + 4 + `DCT_N + 200 + 100;
    localparam int WATCHDOG_NS = (TOTAL_ROWS * 20 + 200) * 10;

    logic       clk;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    pixel_row_t in_row;
    logic       out_valid;
    logic       out_ready;
    coef_row_t  out_row;

    // Scoreboard, expected rows in order and the cycle each input was accepted
    coef_row_t  expected_rows [$];
    int         xfer_cycles [$];

    int         value_errors;
    int         protocol_errors;
    int         rows_checked;
    int         cycle;
    int         sent_cycle;
    logic       latency_check;
    logic       toggle_ready;
    // Output was held back on the previous edge
    logic       stalled;
    coef_row_t  stalled_row;

    dct_row_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_row    (in_row),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_row   (out_row)
    );

    `include "tb_dct_row_tasks.svh"

    always #5 clk = ~clk;

    // Output pacing, random only in the back-pressure test
    always @(posedge clk) begin
        #1;
        out_ready = toggle_ready ? (($urandom % 2) != 0) : 1'b1;
    end

    // Monitor sees pre-edge values, so transfers match what the DUT saw
    always @(posedge clk) begin
        if (reset) begin
            stalled = 1'b0;
        end else begin
            cycle++;
            if (in_valid && in_ready) begin
                xfer_cycles.push_back(cycle);
            end
            if (stalled) begin
                if (!out_valid) begin
                    protocol_errors++;
                    $display("out_valid dropped while out_ready was low, cycle %0d", cycle);
                end
                check_coef_row("out_row", out_row, stalled_row);
            end
            if (out_valid && out_ready) begin
                if (expected_rows.size() == 0) begin
                    protocol_errors++;
                    $display("output row at cycle %0d with no row pending", cycle);
                end else begin
                    check_coef_row("out_row", out_row, expected_rows.pop_front());
                    sent_cycle = xfer_cycles.pop_front();
                    if (latency_check && (cycle - sent_cycle != 2)) begin
                        protocol_errors++;
                        $display("row arrived %0d cycles after its input, expected 2",
                                 cycle - sent_cycle);
                    end
                    rows_checked++;
                end
            end
            stalled     = out_valid && !out_ready;
            stalled_row = out_row;
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout, rows stopped moving at cycle %0d", cycle);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h2e82_d003));
        clk             = 1'b0;
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_row          = '0;
        out_ready       = 1'b1;
        value_errors    = 0;
        protocol_errors = 0;
        rows_checked    = 0;
        cycle           = 0;
        latency_check   = 1'b1;
        toggle_ready    = 1'b0;
        stalled         = 1'b0;
        stalled_row     = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_flat_rows();
        test_impulse_rows();
        test_random_stream();
        test_backpressure();

        // Lost or extra rows show up in the count
        if (rows_checked != TOTAL_ROWS) begin
            protocol_errors++;
            $display("%0d rows came out, %0d were sent", rows_checked, TOTAL_ROWS);
        end
        $display("errors: %0d value, %0d protocol, %0d rows checked",
                 value_errors, protocol_errors, rows_checked);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
+incdir+verification
design/dct_types_pkg.sv
design/dct_coef_pkg.sv
design/dct_pipe_ctrl.sv
design/dct_input_butterfly.sv
design/dct_even_part.sv
design/dct_odd_part.sv
design/dct_row_top.sv
verification/tb_dct_row.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the row DCT testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_dct_row -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
